//--- files.f
+incdir+.
cache_cpu_pkg.sv
cache_mem_pkg.sv
cache_tagv_dirty.sv
cache_data_banks.sv
cache_ctrl.sv
cache_top.sv
tb_clock_gen.sv
cache_chk.sv
cache_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f files.f --top-module cache_tb -Mdir obj_dir -o cache_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cache_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Testbench passed" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

//--- cache_tb.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_tb
  import cache_cpu_pkg::*;
  import cache_mem_pkg::*;
();

  localparam int NUM_ENTRIES = 24;
  // 40 cycles per entry plus reset
  localparam int CYCLE_LIMIT = NUM_ENTRIES * 40 + 10;

  // how an entry is expected to complete
  typedef enum logic [1:0] {
    path_miss,
    path_hit,
    path_any
  } path_e;

  typedef struct packed {
    cpu_op_e                    op;
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [`CACHE_STRB_W-1:0]   wstrb;
    logic [`CACHE_WORD_W-1:0]   wdata;
    path_e                      path;
    logic [`CACHE_WORD_W-1:0]   exp_rdata;
  } stim_t;

  logic                     clk_g;
  logic                     resetn;
  logic                     valid = 1'b0;
  cpu_req_t                 req = '0;
  logic                     wr_rdy = 1'b0;
  logic                     rd_rdy = 1'b0;
  logic                     ret_valid = 1'b0;
  logic                     ret_last = 1'b0;
  logic [`CACHE_WORD_W-1:0] ret_data = '0;
  logic                     addr_ok;
  logic                     data_ok;
  logic [`CACHE_WORD_W-1:0] rdata;
  mem_rd_req_t              mem_rd;
  mem_wr_req_t              mem_wr;

  int pass_cnt = 0;
  int fail_cnt = 0;
  int cycles = 0;
  int seed = 85;

  // memory model holds written lines only
  logic [`CACHE_WORD_W-1:0] mem_store [logic [`CACHE_ADDR_W-1:0]];
  logic [`CACHE_ADDR_W-1:0] rd_addr = '0;
  logic [1:0]               ret_idx = '0;
  logic                     returning = 1'b0;
  logic [31:0]              rnd;

  // op, tag, index, offset, wstrb, wdata, path, expected rdata
  stim_t stim_tab [NUM_ENTRIES] = '{
    '{op_read,  20'h00001, 8'h10, 4'h4, 4'h0, 32'h0,         path_miss, 32'h0000_1104},
    '{op_read,  20'h00001, 8'h10, 4'h4, 4'h0, 32'h0,         path_hit,  32'h0000_1104},
    '{op_write, 20'h00001, 8'h10, 4'h8, 4'h5, 32'hAABB_CCDD, path_hit,  32'h0},
    '{op_read,  20'h00001, 8'h10, 4'h8, 4'h0, 32'h0,         path_hit,  32'h00BB_11DD},
    '{op_write, 20'h00002, 8'h20, 4'h4, 4'hC, 32'h1234_5678, path_miss, 32'h0},
    '{op_read,  20'h00002, 8'h20, 4'h0, 4'h0, 32'h0,         path_hit,  32'h0000_2200},
    '{op_read,  20'h00002, 8'h20, 4'h8, 4'h0, 32'h0,         path_hit,  32'h0000_2208},
    '{op_read,  20'h00002, 8'h20, 4'h4, 4'h0, 32'h0,         path_hit,  32'h1234_2204},
    '{op_write, 20'h0000A, 8'h30, 4'h0, 4'hF, 32'hDEAD_000A, path_miss, 32'h0},
    '{op_write, 20'h0000B, 8'h30, 4'h0, 4'hF, 32'hDEAD_000B, path_miss, 32'h0},
    '{op_write, 20'h0000C, 8'h30, 4'h0, 4'hF, 32'hDEAD_000C, path_miss, 32'h0},
    '{op_read,  20'h0000A, 8'h30, 4'h0, 4'h0, 32'h0,         path_any,  32'hDEAD_000A},
    '{op_read,  20'h0000B, 8'h30, 4'h0, 4'h0, 32'h0,         path_any,  32'hDEAD_000B},
    '{op_read,  20'h0000C, 8'h30, 4'h0, 4'h0, 32'h0,         path_any,  32'hDEAD_000C},
    '{op_read,  20'h0000A, 8'h30, 4'h4, 4'h0, 32'h0,         path_any,  32'h0000_A304},
    '{op_read,  20'h00005, 8'h40, 4'h0, 4'h0, 32'h0,         path_miss, 32'h0000_5400},
    '{op_read,  20'h00005, 8'h41, 4'h4, 4'h0, 32'h0,         path_miss, 32'h0000_5414},
    '{op_read,  20'h00005, 8'h42, 4'h8, 4'h0, 32'h0,         path_miss, 32'h0000_5428},
    '{op_read,  20'h00005, 8'h43, 4'hC, 4'h0, 32'h0,         path_miss, 32'h0000_543C},
    '{op_read,  20'h00005, 8'h40, 4'h0, 4'h0, 32'h0,         path_hit,  32'h0000_5400},
    '{op_read,  20'h00005, 8'h41, 4'h4, 4'h0, 32'h0,         path_hit,  32'h0000_5414},
    '{op_read,  20'h00005, 8'h42, 4'h8, 4'h0, 32'h0,         path_hit,  32'h0000_5428},
    '{op_read,  20'h00005, 8'h43, 4'hC, 4'h0, 32'h0,         path_hit,  32'h0000_543C},
    '{op_read,  20'h00001, 8'h10, 4'h8, 4'h0, 32'h0,         path_hit,  32'h00BB_11DD}
  };

  tb_clock_gen u_clk (.clk_g, .resetn);

  cache_top DUT (
    .clk_g, .resetn, .valid, .req, .wr_rdy, .rd_rdy, .ret_valid, .ret_last, .ret_data,
    .addr_ok, .data_ok, .rdata, .mem_rd, .mem_wr
  );

  // unwritten words read back as their own address
  function automatic logic [`CACHE_WORD_W-1:0] mem_word(input logic [`CACHE_ADDR_W-1:0] addr);
    if (mem_store.exists(addr)) begin
      return mem_store[addr];
    end
    return addr;
  endfunction

  // write-back line capture and the run limit
  always @(posedge clk_g) begin
    cycles = cycles + 1;
    if (resetn && mem_wr.req) begin
      for (int b = 0; b < `CACHE_BANKS; b++) begin
        mem_store[mem_wr.addr + 32'(b * 4)] = mem_wr.data[b];
      end
    end
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: entries did not complete within %0d cycles", CYCLE_LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  // memory responses with random wr_rdy, rd_rdy delay and ret_valid gaps
  always @(negedge clk_g) begin
    rnd = $random(seed);
    if (!resetn) begin
      wr_rdy    = 1'b0;
      rd_rdy    = 1'b0;
      ret_valid = 1'b0;
      ret_last  = 1'b0;
      returning = 1'b0;
    end else begin
      wr_rdy    = rnd[0];
      ret_valid = 1'b0;
      ret_last  = 1'b0;
      if (rd_rdy) begin
        // request taken at the last edge
        rd_rdy    = 1'b0;
        returning = 1'b1;
        ret_idx   = 2'd0;
      end else if (returning) begin
        if (rnd[2:1] != 2'b00) begin
          ret_valid = 1'b1;
          ret_data  = mem_word(rd_addr + {28'd0, ret_idx, 2'b00});
          ret_last  = (ret_idx == 2'd3);
          returning = (ret_idx != 2'd3);
          ret_idx   = ret_idx + 2'd1;
        end
      end else if (mem_rd.req) begin
        rd_rdy  = rnd[3];
        rd_addr = mem_rd.addr;
      end
    end
  end

  task automatic apply_entry(input int i);
    stim_t e;
    int lat;
    e = stim_tab[i];
    lat = 1;
    @(negedge clk_g);
    while (!addr_ok) @(negedge clk_g);
    valid = 1'b1;
    req   = '{e.op, e.tag, e.index, e.offset, e.wstrb, e.wdata};
    // addr_ok only falls on a state change so the next edge accepts
    @(negedge clk_g);
    valid = 1'b0;
    // a hit completes in the cycle after acceptance
    @(posedge clk_g);
    while (!data_ok) begin
      @(posedge clk_g);
      lat++;
    end
    if ((e.op == op_read) && (rdata !== e.exp_rdata)) begin
      $display("FAIL %0t: entry %0d read of %h returned %h, expected %h", $time, i,
               {e.tag, e.index, e.offset}, rdata, e.exp_rdata);
      fail_cnt++;
    end else if (((e.path == path_hit) && (lat != 1)) ||
                 ((e.path == path_miss) && (lat == 1))) begin
      $display("FAIL %0t: entry %0d took %0d cycles to data_ok, expected a %s", $time, i,
               lat, (e.path == path_hit) ? "hit" : "miss");
      fail_cnt++;
    end else begin
      $display("ok %0t: entry %0d %s %h", $time, i, e.op.name(), {e.tag, e.index, e.offset});
      pass_cnt++;
    end
  endtask

  initial begin
    @(posedge resetn);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      apply_entry(i);
    end
    $display("entries %0d, passed %0d, failed %0d", NUM_ENTRIES, pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- cache_chk.sv
`timescale 1ns/10ps

module cache_chk (
  input logic clk_g,
  input logic resetn,
  input logic addr_ok,
  input logic data_ok,
  input logic wr_rdy,
  input logic rd_rdy,
  input logic wr_req,
  input logic rd_req
);

  // write-back is a single pulse inside a wr_rdy cycle
  wr_req_with_rdy: assert property (@(posedge clk_g) disable iff (!resetn)
    wr_req |-> wr_rdy)
    else $error("wr_req raised while wr_rdy low");

  wr_req_one_cycle: assert property (@(posedge clk_g) disable iff (!resetn)
    wr_req |=> !wr_req)
    else $error("wr_req held longer than one cycle");

  // line request waits for the memory
  rd_req_held: assert property (@(posedge clk_g) disable iff (!resetn)
    rd_req && !rd_rdy |=> rd_req)
    else $error("rd_req dropped before rd_rdy");

  no_ok_overlap: assert property (@(posedge clk_g) disable iff (!resetn)
    !(data_ok && addr_ok))
    else $error("data_ok and addr_ok high together");

endmodule

bind cache_top cache_chk u_chk (
  .clk_g, .resetn, .addr_ok, .data_ok, .wr_rdy, .rd_rdy,
  .wr_req(mem_wr.req), .rd_req(mem_rd.req)
);

//--- tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_g,
  output logic resetn
);

  // 4 ns period
  initial begin
    clk_g = 1'b0;
    forever #2 clk_g = ~clk_g;
  end

  // low over the first 5 rising edges, released on a falling edge
  initial begin
    resetn = 1'b0;
    repeat (5) @(posedge clk_g);
    @(negedge clk_g);
    resetn = 1'b1;
  end

endmodule

//--- cache_top.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_top
  import cache_cpu_pkg::*;
  import cache_mem_pkg::*;
(
  input  logic                     clk_g,
  input  logic                     resetn,
  input  logic                     valid,
  input  cpu_req_t                 req,
  input  logic                     wr_rdy,
  input  logic                     rd_rdy,
  input  logic                     ret_valid,
  input  logic                     ret_last,
  input  logic [`CACHE_WORD_W-1:0] ret_data,
  output logic                     addr_ok,
  output logic                     data_ok,
  output logic [`CACHE_WORD_W-1:0] rdata,
  output mem_rd_req_t              mem_rd,
  output mem_wr_req_t              mem_wr
);

  way_vec_t   hit;
  way_vec_t   way_valid;
  way_vec_t   way_dirty;
  way_tags_t  way_tags;
  way_lines_t lines;

  logic                      rd_en;
  logic [`CACHE_INDEX_W-1:0] rd_index;
  logic [`CACHE_TAG_W-1:0]   cmp_tag;
  logic [`CACHE_INDEX_W-1:0] buf_index;
  logic                      fill_en;
  logic                      fill_way;
  logic                      fill_dirty;
  logic                      dirty_en;
  logic                      dirty_way;
  logic                      wr_en;
  logic                      wr_way;
  logic [`CACHE_BANK_W-1:0]  wr_bank;
  logic [`CACHE_STRB_W-1:0]  wr_strb;
  logic [`CACHE_WORD_W-1:0]  wr_word;

  cache_ctrl u_ctrl (
    .clk_g, .resetn, .valid, .req, .hit, .way_valid, .way_dirty, .way_tags, .lines,
    .wr_rdy, .rd_rdy, .ret_valid, .ret_last, .ret_data,
    .addr_ok, .data_ok, .rdata, .mem_rd, .mem_wr,
    .rd_en, .rd_index, .cmp_tag, .buf_index, .fill_en, .fill_way, .fill_dirty,
    .dirty_en, .dirty_way, .wr_en, .wr_way, .wr_bank, .wr_strb, .wr_word
  );

  // fill tag is the buffered request tag
  cache_tagv_dirty u_tagv (
    .clk_g, .resetn, .rd_en, .rd_index, .cmp_tag,
    .fill_en, .fill_way, .fill_index(buf_index), .fill_tag(cmp_tag), .fill_dirty,
    .dirty_en, .dirty_way, .dirty_index(buf_index),
    .hit, .valid(way_valid), .dirty(way_dirty), .tags(way_tags)
  );

  cache_data_banks u_data (
    .clk_g, .rd_en, .rd_index, .wr_en, .wr_way, .wr_index(buf_index),
    .wr_bank, .wr_strb, .wr_word, .lines
  );

endmodule

//--- cache_ctrl.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_ctrl
  import cache_cpu_pkg::*;
  import cache_mem_pkg::*;
(
  input  logic                      clk_g,
  input  logic                      resetn,
  input  logic                      valid,
  input  cpu_req_t                  req,
  input  way_vec_t                  hit,
  input  way_vec_t                  way_valid,
  input  way_vec_t                  way_dirty,
  input  way_tags_t                 way_tags,
  input  way_lines_t                lines,
  input  logic                      wr_rdy,
  input  logic                      rd_rdy,
  input  logic                      ret_valid,
  input  logic                      ret_last,
  input  logic [`CACHE_WORD_W-1:0]  ret_data,
  output logic                      addr_ok,
  output logic                      data_ok,
  output logic [`CACHE_WORD_W-1:0]  rdata,
  output mem_rd_req_t               mem_rd,
  output mem_wr_req_t               mem_wr,
  output logic                      rd_en,
  output logic [`CACHE_INDEX_W-1:0] rd_index,
  output logic [`CACHE_TAG_W-1:0]   cmp_tag,
  output logic [`CACHE_INDEX_W-1:0] buf_index,
  output logic                      fill_en,
  output logic                      fill_way,
  output logic                      fill_dirty,
  output logic                      dirty_en,
  output logic                      dirty_way,
  output logic                      wr_en,
  output logic                      wr_way,
  output logic [`CACHE_BANK_W-1:0]  wr_bank,
  output logic [`CACHE_STRB_W-1:0]  wr_strb,
  output logic [`CACHE_WORD_W-1:0]  wr_word
);

  ctrl_state_e state;
  ctrl_state_e state_nxt;
  cpu_req_t req_q;
  logic victim_way;
  logic [3:0] lfsr;
  logic [`CACHE_BANK_W-1:0] ret_cnt;
  logic [`CACHE_BANK_W-1:0] req_bank;
  logic lookup_hit;
  logic hit_way;
  logic write_hit;
  logic victim_wb;
  logic in_refill;
  logic ret_req_word;
  logic [`CACHE_WORD_W-1:0] refill_word;

  assign req_bank = req_q.offset[`CACHE_OFFSET_W-1:2];
  assign lookup_hit = (state == st_lookup) && (|hit);
  assign hit_way = hit[1];
  assign write_hit = lookup_hit && (req_q.op == op_write);
  assign victim_wb = way_valid[victim_way] && way_dirty[victim_way];
  assign in_refill = (state == st_refill);
  assign ret_req_word = in_refill && ret_valid && (ret_cnt == req_bank);

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:
        if (valid)
          state_nxt = st_lookup;
      st_lookup:
        state_nxt = (|hit) ? st_idle : st_miss;
      // write-back slot, taken even for a clean victim
      st_miss:
        if (wr_rdy)
          state_nxt = st_replace;
      st_replace:
        if (rd_rdy)
          state_nxt = st_refill;
      st_refill:
        if (ret_valid && ret_last)
          state_nxt = st_idle;
      default:
        state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      state      <= st_idle;
      victim_way <= 1'b0;
      lfsr       <= 4'b0001;
      ret_cnt    <= '0;
    end else begin
      state <= state_nxt;
      // x^4 + x^3 + 1
      lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
      // invalid way first, else random
      if ((state == st_lookup) && !(|hit)) begin
        victim_way <= !way_valid[0] ? 1'b0 : (!way_valid[1] ? 1'b1 : lfsr[0]);
      end
      if (state == st_replace) begin
        ret_cnt <= '0;
      end else if (in_refill && ret_valid) begin
        ret_cnt <= ret_cnt + 1'b1;
      end
    end
  end

  // request buffer
  always_ff @(posedge clk_g) begin
    if (valid && addr_ok) begin
      req_q <= req;
    end
  end

  // returned word, store bytes merged in for a write miss
  always_comb begin
    refill_word = ret_data;
    if (ret_req_word && (req_q.op == op_write)) begin
      for (int i = 0; i < `CACHE_STRB_W; i++) begin
        if (req_q.wstrb[i]) begin
          refill_word[i*8 +: 8] = req_q.wdata[i*8 +: 8];
        end
      end
    end
  end

  assign addr_ok = (state == st_idle);
  assign data_ok = lookup_hit || ret_req_word;
  assign rdata   = in_refill ? ret_data : lines[hit_way][req_bank];

  assign mem_rd.req  = (state == st_replace);
  assign mem_rd.addr = {req_q.tag, req_q.index, {`CACHE_OFFSET_W{1'b0}}};

  assign mem_wr.req  = (state == st_miss) && wr_rdy && victim_wb;
  assign mem_wr.addr = {way_tags[victim_way], req_q.index, {`CACHE_OFFSET_W{1'b0}}};
  assign mem_wr.data = lines[victim_way];

  // array reads at acceptance
  assign rd_en     = valid && addr_ok;
  assign rd_index  = req.index;
  assign cmp_tag   = req_q.tag;
  assign buf_index = req_q.index;

  assign fill_en    = in_refill && ret_valid && ret_last;
  assign fill_way   = victim_way;
  assign fill_dirty = (req_q.op == op_write);
  assign dirty_en   = write_hit;
  assign dirty_way  = hit_way;

  assign wr_en   = write_hit || (in_refill && ret_valid);
  assign wr_way  = in_refill ? victim_way : hit_way;
  assign wr_bank = in_refill ? ret_cnt : req_bank;
  assign wr_strb = in_refill ? {`CACHE_STRB_W{1'b1}} : req_q.wstrb;
  assign wr_word = in_refill ? refill_word : req_q.wdata;

endmodule

//--- cache_data_banks.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_data_banks
  import cache_mem_pkg::*;
(
  input  logic                      clk_g,
  input  logic                      rd_en,
  input  logic [`CACHE_INDEX_W-1:0] rd_index,
  input  logic                      wr_en,
  input  logic                      wr_way,
  input  logic [`CACHE_INDEX_W-1:0] wr_index,
  input  logic [`CACHE_BANK_W-1:0]  wr_bank,
  input  logic [`CACHE_STRB_W-1:0]  wr_strb,
  input  logic [`CACHE_WORD_W-1:0]  wr_word,
  output way_lines_t                lines
);

  // one word array per way and bank
  logic [`CACHE_WORD_W-1:0] bank_mem [`CACHE_WAYS][`CACHE_BANKS][`CACHE_SETS];

  // byte strobed write of one word
  always_ff @(posedge clk_g) begin
    if (wr_en) begin
      for (int i = 0; i < `CACHE_STRB_W; i++) begin
        if (wr_strb[i]) begin
          bank_mem[wr_way][wr_bank][wr_index][i*8 +: 8] <= wr_word[i*8 +: 8];
        end
      end
    end
  end

  // full line of both ways, held until next read
  always_ff @(posedge clk_g) begin
    if (rd_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        for (int b = 0; b < `CACHE_BANKS; b++) begin
          lines[w][b] <= bank_mem[w][b][rd_index];
        end
      end
    end
  end

endmodule

//--- cache_tagv_dirty.sv
`timescale 1ns/10ps
`include "cache_defines.svh"

module cache_tagv_dirty
  import cache_mem_pkg::*;
(
  input  logic                      clk_g,
  input  logic                      resetn,
  input  logic                      rd_en,
  input  logic [`CACHE_INDEX_W-1:0] rd_index,
  input  logic [`CACHE_TAG_W-1:0]   cmp_tag,
  input  logic                      fill_en,
  input  logic                      fill_way,
  input  logic [`CACHE_INDEX_W-1:0] fill_index,
  input  logic [`CACHE_TAG_W-1:0]   fill_tag,
  input  logic                      fill_dirty,
  input  logic                      dirty_en,
  input  logic                      dirty_way,
  input  logic [`CACHE_INDEX_W-1:0] dirty_index,
  output way_vec_t                  hit,
  output way_vec_t                  valid,
  output way_vec_t                  dirty,
  output way_tags_t                 tags
);

  logic [`CACHE_TAG_W-1:0] tag_mem [`CACHE_WAYS][`CACHE_SETS];
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid_bits;
  logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] dirty_bits;

  // tag storage
  always_ff @(posedge clk_g) begin
    if (fill_en) begin
      tag_mem[fill_way][fill_index] <= fill_tag;
    end
  end

  // valid and dirty flops
  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else begin
      if (fill_en) begin
        valid_bits[fill_way][fill_index] <= 1'b1;
        dirty_bits[fill_way][fill_index] <= fill_dirty;
      end
      // write hit marks the line
      if (dirty_en) begin
        dirty_bits[dirty_way][dirty_index] <= 1'b1;
      end
    end
  end

  // registered set read, both ways
  always_ff @(posedge clk_g) begin
    if (!resetn) begin
      valid <= '0;
      dirty <= '0;
    end else if (rd_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        valid[w] <= valid_bits[w][rd_index];
        dirty[w] <= dirty_bits[w][rd_index];
      end
    end
  end

  always_ff @(posedge clk_g) begin
    if (rd_en) begin
      for (int w = 0; w < `CACHE_WAYS; w++) begin
        tags[w] <= tag_mem[w][rd_index];
      end
    end
  end

  // hit compare on the held read
  always_comb begin
    for (int w = 0; w < `CACHE_WAYS; w++) begin
      hit[w] = valid[w] && (tags[w] == cmp_tag);
    end
  end

endmodule

//--- cache_mem_pkg.sv
`include "cache_defines.svh"

package cache_mem_pkg;

  // one line, bank 0 in the low word
  typedef logic [`CACHE_BANKS-1:0][`CACHE_WORD_W-1:0] line_t;

  // per-way views of a set
  typedef logic [`CACHE_WAYS-1:0] way_vec_t;
  typedef logic [`CACHE_WAYS-1:0][`CACHE_TAG_W-1:0] way_tags_t;
  typedef line_t [`CACHE_WAYS-1:0] way_lines_t;

  // line read request, addr is line aligned
  typedef struct packed {
    logic                     req;
    logic [`CACHE_ADDR_W-1:0] addr;
  } mem_rd_req_t;

  // line write-back pulse
  typedef struct packed {
    logic                     req;
    logic [`CACHE_ADDR_W-1:0] addr;
    line_t                    data;
  } mem_wr_req_t;

endpackage

//--- cache_cpu_pkg.sv
`include "cache_defines.svh"

package cache_cpu_pkg;

  // cpu op encoding
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } cpu_op_e;

  // request as presented with valid
  typedef struct packed {
    cpu_op_e                    op;
    logic [`CACHE_TAG_W-1:0]    tag;
    logic [`CACHE_INDEX_W-1:0]  index;
    logic [`CACHE_OFFSET_W-1:0] offset;
    logic [`CACHE_STRB_W-1:0]   wstrb;
    logic [`CACHE_WORD_W-1:0]   wdata;
  } cpu_req_t;

  // main controller states
  typedef enum logic [2:0] {
    st_idle    = 3'd0,
    st_lookup  = 3'd1,
    st_miss    = 3'd2,
    st_replace = 3'd3,
    st_refill  = 3'd4
  } ctrl_state_e;

endpackage

//--- cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// address split
`define CACHE_TAG_W      20
`define CACHE_INDEX_W    8
`define CACHE_OFFSET_W   4
`define CACHE_ADDR_W     (`CACHE_TAG_W + `CACHE_INDEX_W + `CACHE_OFFSET_W)

// data widths
`define CACHE_WORD_W     32
`define CACHE_STRB_W     (`CACHE_WORD_W / 8)

// line geometry
`define CACHE_LINE_BYTES 16
`define CACHE_BANKS      (`CACHE_LINE_BYTES * 8 / `CACHE_WORD_W)
`define CACHE_BANK_W     2

// sets and ways
`define CACHE_SETS       (1 << `CACHE_INDEX_W)
`define CACHE_WAYS       2

`endif
